//--- flist.f
rtl/mbus_pkg.sv
rtl/ice_msg_pkg.sv
rtl/mbus_tx_driver.sv
rtl/mbus_rx_driver.sv
rtl/ack_generator.sv
rtl/mbus_layer_wrapper.sv
verification/clock_gen.sv
verification/mbus_layer_checker.sv
verification/tb_mbus_layer_wrapper.sv

//--- rtl/ack_generator.sv
`timescale 1ns/100ps

module ack_generator (
    input  logic               clk,
    input  logic               reset,
    input  logic               gen_ack,
    input  logic               gen_nak,
    input  ice_msg_pkg::eid_t  eid,
    output ice_msg_pkg::char_t ack_data,
    output logic               ack_data_valid,
    output logic               ack_frame_valid
);
    import ice_msg_pkg::*;

    logic [1:0] byte_idx;
    logic       start;
    eid_t       eid_q;

    assign start = gen_ack | gen_nak;

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_idx        <= 2'd0;
            ack_data_valid  <= 1'b0;
            ack_frame_valid <= 1'b0;
        end else if (start) begin
            // Code byte goes out right away
            byte_idx        <= 2'd1;
            ack_data_valid  <= 1'b1;
            ack_frame_valid <= 1'b1;
        end else if (ack_frame_valid) begin
            if (byte_idx == ACK_MSG_LEN) begin
                byte_idx        <= 2'd0;
                ack_data_valid  <= 1'b0;
                ack_frame_valid <= 1'b0;
            end else begin
                byte_idx <= byte_idx + 2'd1;
            end
        end
    end

    // Code, event id, then a zero byte
    always_ff @(posedge clk) begin
        if (start) begin
            ack_data <= gen_nak ? MSG_NAK : MSG_ACK;
            eid_q    <= eid;
        end else if (byte_idx == 2'd1) begin
            ack_data <= eid_q;
        end else if (byte_idx == 2'd2) begin
            ack_data <= 8'h00;
        end
    end

endmodule

//--- rtl/ice_msg_pkg.sv
package ice_msg_pkg;

    // Host byte stream
    typedef logic [7:0] char_t;
    typedef logic [7:0] eid_t;

    // Message codes sent back to the host
    localparam char_t MSG_ACK = 8'h00;
    localparam char_t MSG_NAK = 8'h01;
    localparam char_t MSG_RX  = 8'h62;

    // Message lengths in bytes, sized for each generator's byte counter
    localparam logic [1:0] ACK_MSG_LEN = 2'd3;
    localparam logic [3:0] RX_MSG_LEN  = 4'd11;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_GATHER,
        TX_REQUEST,
        TX_WAIT_RESULT,
        TX_REPORT
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_EMIT,
        RX_RELEASE
    } rx_state_t;

endpackage

//--- rtl/mbus_layer_wrapper.sv
`timescale 1ns/100ps

module mbus_layer_wrapper (
    input  logic                  clk,
    input  logic                  reset,

    // Board configuration
    input  mbus_pkg::clk_div_t    mbus_clk_div,
    input  mbus_pkg::short_addr_t short_addr_override,
    output logic                  mbus_clk,

    // Host frame in
    input  logic                  host_frame_valid,
    input  ice_msg_pkg::eid_t     host_eid,
    input  ice_msg_pkg::char_t    host_char,
    input  logic                  host_char_valid,
    output logic                  char_advance,

    // Controller TX port
    output mbus_pkg::mbus_word_t  tx_addr,
    output mbus_pkg::mbus_word_t  tx_data,
    output logic                  tx_req,
    output logic                  tx_pend,
    input  logic                  tx_ack,
    input  logic                  tx_fail,
    input  logic                  tx_succ,
    output logic                  tx_resp_ack,

    // Controller RX port
    input  mbus_pkg::mbus_word_t  rx_addr,
    input  mbus_pkg::mbus_word_t  rx_data,
    input  logic                  rx_req,
    input  logic                  rx_pend,
    input  logic                  rx_fail,
    input  logic                  rx_broadcast,
    input  mbus_pkg::ctrl_bits_t  rx_ctrl_bits,
    output logic                  rx_ack,

    // Short address register port of the controller
    input  logic                  addr_write,
    input  logic                  addr_invalid,
    input  mbus_pkg::short_addr_t addr_write_value,
    output mbus_pkg::short_addr_t assigned_addr,
    output logic                  assigned_addr_valid,

    // Host message streams out
    output ice_msg_pkg::char_t    ack_data,
    output logic                  ack_data_valid,
    output logic                  ack_frame_valid,
    output ice_msg_pkg::char_t    rx_data_out,
    output logic                  rx_data_valid,
    output logic                  rx_frame_valid,

    input  ice_msg_pkg::char_t    global_counter,
    output logic                  global_counter_inc
);
    import mbus_pkg::*;
    import ice_msg_pkg::*;

    clk_div_t    mbus_clk_count;
    logic [7:0]  sync_meta;
    logic [7:0]  sync_out;
    logic        tx_ack_sync, tx_succ_sync, tx_fail_sync;
    logic        rx_req_sync, rx_pend_sync, rx_fail_sync;
    logic        addr_write_sync, addr_invalid_sync;
    short_addr_t reg_addr;
    logic        reg_addr_valid;
    eid_t        frame_eid;
    logic        gen_ack, gen_nak;

    // MBus clock, toggles every mbus_clk_div+1 cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            mbus_clk_count <= '0;
            mbus_clk       <= 1'b0;
        end else if (mbus_clk_count == mbus_clk_div) begin
            mbus_clk_count <= '0;
            mbus_clk       <= ~mbus_clk;
        end else begin
            mbus_clk_count <= mbus_clk_count + clk_div_t'(1);
        end
    end

    // Two-flop synchronizers for the controller strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta <= 8'h00;
            sync_out  <= 8'h00;
        end else begin
            sync_meta <= {addr_invalid, addr_write, rx_fail, rx_pend,
                          rx_req, tx_fail, tx_succ, tx_ack};
            sync_out  <= sync_meta;
        end
    end

    assign tx_ack_sync       = sync_out[0];
    assign tx_succ_sync      = sync_out[1];
    assign tx_fail_sync      = sync_out[2];
    assign rx_req_sync       = sync_out[3];
    assign rx_pend_sync      = sync_out[4];
    assign rx_fail_sync      = sync_out[5];
    assign addr_write_sync   = sync_out[6];
    assign addr_invalid_sync = sync_out[7];

    // Address assigned through the controller, write wins over invalidate
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_addr       <= SHORT_ADDR_NONE;
            reg_addr_valid <= 1'b0;
        end else if (addr_write_sync) begin
            reg_addr       <= addr_write_value;
            reg_addr_valid <= 1'b1;
        end else if (addr_invalid_sync) begin
            reg_addr       <= SHORT_ADDR_NONE;
            reg_addr_valid <= 1'b0;
        end
    end

    // A host-set address overrides the enumerated one
    always_comb begin
        if (short_addr_override != SHORT_ADDR_NONE) begin
            assigned_addr       = short_addr_override;
            assigned_addr_valid = 1'b1;
        end else begin
            assigned_addr       = reg_addr;
            assigned_addr_valid = reg_addr_valid;
        end
    end

    // Event id kept past the end of the frame for the late ACK/NAK
    always_ff @(posedge clk) begin
        if (host_frame_valid) begin
            frame_eid <= host_eid;
        end
    end

    mbus_tx_driver i_mbus_tx_driver (
        .clk              (clk),
        .reset            (reset),
        .host_frame_valid (host_frame_valid),
        .host_char        (host_char),
        .host_char_valid  (host_char_valid),
        .char_advance     (char_advance),
        .tx_addr          (tx_addr),
        .tx_data          (tx_data),
        .tx_req           (tx_req),
        .tx_pend          (tx_pend),
        .tx_ack           (tx_ack_sync),
        .tx_succ          (tx_succ_sync),
        .tx_fail          (tx_fail_sync),
        .tx_resp_ack      (tx_resp_ack),
        .gen_ack          (gen_ack),
        .gen_nak          (gen_nak)
    );

    mbus_rx_driver i_mbus_rx_driver (
        .clk                (clk),
        .reset              (reset),
        .rx_addr            (rx_addr),
        .rx_data            (rx_data),
        .rx_broadcast       (rx_broadcast),
        .rx_ctrl_bits       (rx_ctrl_bits),
        .rx_req             (rx_req_sync),
        .rx_pend            (rx_pend_sync),
        .rx_fail            (rx_fail_sync),
        .rx_ack             (rx_ack),
        .global_counter     (global_counter),
        .global_counter_inc (global_counter_inc),
        .rx_data_out        (rx_data_out),
        .rx_data_valid      (rx_data_valid),
        .rx_frame_valid     (rx_frame_valid)
    );

    ack_generator i_ack_generator (
        .clk             (clk),
        .reset           (reset),
        .gen_ack         (gen_ack),
        .gen_nak         (gen_nak),
        .eid             (frame_eid),
        .ack_data        (ack_data),
        .ack_data_valid  (ack_data_valid),
        .ack_frame_valid (ack_frame_valid)
    );

endmodule

//--- rtl/mbus_pkg.sv
package mbus_pkg;

    // Widths seen on the MBus controller side
    localparam int MBUS_WORD_W  = 32;
    localparam int LONG_ADDR_W  = 20;
    localparam int SHORT_ADDR_W = 4;
    localparam int CTRL_BITS_W  = 2;

    // Compare value width of the MBus clock divider
    localparam int CLK_DIV_W = 22;

    // One address or data word of an MBus transaction
    typedef logic [MBUS_WORD_W-1:0] mbus_word_t;

    // Full-prefix node address
    typedef logic [LONG_ADDR_W-1:0] long_addr_t;

    // Enumerated short address
    typedef logic [SHORT_ADDR_W-1:0] short_addr_t;

    // Control bits exported by the controller with each received message
    typedef logic [CTRL_BITS_W-1:0] ctrl_bits_t;

    typedef logic [CLK_DIV_W-1:0] clk_div_t;

    // Short address meaning "not assigned"; also the override's "no override" value
    localparam short_addr_t SHORT_ADDR_NONE = 4'hf;

endpackage

//--- rtl/mbus_rx_driver.sv
`timescale 1ns/100ps

module mbus_rx_driver (
    input  logic                 clk,
    input  logic                 reset,

    // Controller RX port, strobes already synchronized
    input  mbus_pkg::mbus_word_t rx_addr,
    input  mbus_pkg::mbus_word_t rx_data,
    input  logic                 rx_broadcast,
    input  mbus_pkg::ctrl_bits_t rx_ctrl_bits,
    input  logic                 rx_req,
    input  logic                 rx_pend,
    input  logic                 rx_fail,
    output logic                 rx_ack,

    // Time tag
    input  ice_msg_pkg::char_t   global_counter,
    output logic                 global_counter_inc,

    // Host message stream
    output ice_msg_pkg::char_t   rx_data_out,
    output logic                 rx_data_valid,
    output logic                 rx_frame_valid
);
    import mbus_pkg::*;
    import ice_msg_pkg::*;

    rx_state_t  state;
    logic [3:0] byte_idx;
    logic       capture;
    mbus_word_t addr_q;
    mbus_word_t data_q;
    char_t      flags_q;
    char_t      stamp_q;
    char_t      next_byte;

    assign capture = (state == RX_IDLE) & rx_req;

    // Message layout: type, time tag, flags, address, data
    always_comb begin
        case (byte_idx)
            4'd0:    next_byte = MSG_RX;
            4'd1:    next_byte = stamp_q;
            4'd2:    next_byte = flags_q;
            4'd3:    next_byte = addr_q[31:24];
            4'd4:    next_byte = addr_q[23:16];
            4'd5:    next_byte = addr_q[15:8];
            4'd6:    next_byte = addr_q[7:0];
            4'd7:    next_byte = data_q[31:24];
            4'd8:    next_byte = data_q[23:16];
            4'd9:    next_byte = data_q[15:8];
            4'd10:   next_byte = data_q[7:0];
            default: next_byte = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state              <= RX_IDLE;
            byte_idx           <= 4'd0;
            rx_ack             <= 1'b0;
            global_counter_inc <= 1'b0;
            rx_data_valid      <= 1'b0;
            rx_frame_valid     <= 1'b0;
        end else begin
            rx_ack             <= 1'b0;
            global_counter_inc <= 1'b0;

            case (state)
                RX_IDLE: begin
                    if (rx_req) begin
                        rx_ack             <= 1'b1;
                        global_counter_inc <= 1'b1;
                        byte_idx           <= 4'd0;
                        state              <= RX_EMIT;
                    end
                end

                RX_EMIT: begin
                    rx_data_valid  <= 1'b1;
                    rx_frame_valid <= 1'b1;
                    byte_idx       <= byte_idx + 4'd1;
                    if (byte_idx == RX_MSG_LEN - 4'd1) begin
                        state <= RX_RELEASE;
                    end
                end

                RX_RELEASE: begin
                    rx_data_valid  <= 1'b0;
                    rx_frame_valid <= 1'b0;
                    // Next word only after the controller drops its request
                    if (!rx_req) begin
                        state <= RX_IDLE;
                    end
                end

                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            addr_q  <= rx_addr;
            data_q  <= rx_data;
            flags_q <= {3'b000, rx_fail, rx_pend, rx_broadcast, rx_ctrl_bits};
            stamp_q <= global_counter;
        end
        if (state == RX_EMIT) begin
            rx_data_out <= next_byte;
        end
    end

endmodule

//--- rtl/mbus_tx_driver.sv
`timescale 1ns/100ps

module mbus_tx_driver (
    input  logic                 clk,
    input  logic                 reset,

    // Host character stream
    input  logic                 host_frame_valid,
    input  ice_msg_pkg::char_t   host_char,
    input  logic                 host_char_valid,
    output logic                 char_advance,

    // Controller TX port, strobes already synchronized
    output mbus_pkg::mbus_word_t tx_addr,
    output mbus_pkg::mbus_word_t tx_data,
    output logic                 tx_req,
    output logic                 tx_pend,
    input  logic                 tx_ack,
    input  logic                 tx_succ,
    input  logic                 tx_fail,
    output logic                 tx_resp_ack,

    // Outcome pulses for the ACK/NAK message
    output logic                 gen_ack,
    output logic                 gen_nak
);
    import mbus_pkg::*;
    import ice_msg_pkg::*;

    tx_state_t   state;
    logic [1:0]  byte_cnt;
    logic        have_addr;
    logic        word_sent;
    logic [23:0] shift_bytes;
    mbus_word_t  next_word;
    logic        word_done;

    // Characters are only taken while gathering
    assign char_advance = (state == TX_GATHER) & host_frame_valid & host_char_valid;

    // Most significant character arrives first
    assign next_word = {shift_bytes, host_char};
    assign word_done = char_advance & (byte_cnt == 2'd3);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= TX_IDLE;
            byte_cnt    <= 2'd0;
            have_addr   <= 1'b0;
            word_sent   <= 1'b0;
            tx_req      <= 1'b0;
            tx_pend     <= 1'b0;
            tx_resp_ack <= 1'b0;
            gen_ack     <= 1'b0;
            gen_nak     <= 1'b0;
        end else begin
            tx_resp_ack <= 1'b0;
            gen_ack     <= 1'b0;
            gen_nak     <= 1'b0;

            case (state)
                TX_IDLE: begin
                    if (host_frame_valid) begin
                        byte_cnt  <= 2'd0;
                        have_addr <= 1'b0;
                        word_sent <= 1'b0;
                        tx_pend   <= 1'b0;
                        state     <= TX_GATHER;
                    end
                end

                TX_GATHER: begin
                    if (char_advance) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (word_done) begin
                            // First word is the address, every later one a data word
                            if (have_addr) begin
                                state <= TX_REQUEST;
                            end else begin
                                have_addr <= 1'b1;
                            end
                        end
                    end else if (!host_frame_valid) begin
                        // Partial word or address only: reject without a request
                        if (byte_cnt != 2'd0 || !word_sent) begin
                            gen_nak <= 1'b1;
                            state   <= TX_REPORT;
                        end else begin
                            state <= TX_WAIT_RESULT;
                        end
                    end
                end

                TX_REQUEST: begin
                    // Previous acknowledge must have dropped before a new request
                    if (!tx_req && !tx_ack) begin
                        tx_req  <= 1'b1;
                        tx_pend <= host_frame_valid;
                    end else if (tx_req && tx_ack) begin
                        tx_req    <= 1'b0;
                        word_sent <= 1'b1;
                        state     <= tx_pend ? TX_GATHER : TX_WAIT_RESULT;
                    end
                end

                TX_WAIT_RESULT: begin
                    if (tx_succ || tx_fail) begin
                        tx_resp_ack <= 1'b1;
                        gen_ack     <= tx_succ;
                        gen_nak     <= ~tx_succ;
                        state       <= TX_REPORT;
                    end
                end

                TX_REPORT: begin
                    // Wait for the result strobes and the frame to clear
                    if (!tx_succ && !tx_fail && !host_frame_valid) begin
                        state <= TX_IDLE;
                    end
                end

                default: state <= TX_IDLE;
            endcase
        end
    end

    // Word assembly
    always_ff @(posedge clk) begin
        if (char_advance) begin
            shift_bytes <= next_word[23:0];
            if (word_done) begin
                if (have_addr) begin
                    tx_data <= next_word;
                end else begin
                    tx_addr <= next_word;
                end
            end
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench, and decide the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_mbus_layer_wrapper \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log

! grep -q "=== FAIL ===" sim.log && grep -q "=== PASS ===" sim.log \
    && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- verification/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free-running, starts low
    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

//--- verification/mbus_layer_checker.sv
`timescale 1ns/100ps

module mbus_layer_checker (
    input logic clk,
    input logic reset,
    input logic mbus_clk,
    input logic tx_req,
    input logic tx_ack_sync,
    input logic tx_pend,
    input logic tx_resp_ack,
    input logic char_advance,
    input logic rx_ack,
    input logic global_counter_inc,
    input logic ack_data_valid,
    input logic ack_frame_valid,
    input logic rx_data_valid,
    input logic rx_frame_valid
);

    // Request is held until the synchronized acknowledge arrives
    tx_req_held: assert property (@(posedge clk) disable iff (reset)
        tx_req && !tx_ack_sync |=> tx_req)
        else $error("tx_req dropped before tx_ack");

    // Byte strobes only inside their frame
    ack_byte_in_frame: assert property (@(posedge clk) disable iff (reset)
        ack_data_valid |-> ack_frame_valid)
        else $error("ack_data_valid outside ack_frame_valid");

    rx_byte_in_frame: assert property (@(posedge clk) disable iff (reset)
        rx_data_valid |-> rx_frame_valid)
        else $error("rx_data_valid outside rx_frame_valid");

    // All control outputs come out of reset low
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !(mbus_clk || tx_req || tx_pend || tx_resp_ack || char_advance || rx_ack
                    || global_counter_inc || ack_data_valid || ack_frame_valid
                    || rx_data_valid || rx_frame_valid))
        else $error("Control output high in the cycle after reset");

endmodule

//--- verification/tb_mbus_layer_wrapper.sv
`timescale 1ns/100ps

module tb_mbus_layer_wrapper;
    import mbus_pkg::*;
    import ice_msg_pkg::*;

    localparam real CLK_PERIOD   = 8.0;
    localparam int  RESET_CYCLES = 8;
    localparam int  NUM_RX_MSGS  = 8;
    localparam int  MAX_WORDS    = 3;
    // Cycle budget: reset, two divider measurements, four frames, RX burst, address steps
    localparam int  FRAME_CYCLES   = (MAX_WORDS + 1) * 30 + 40;
    localparam int  TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 60 + 4 * FRAME_CYCLES
                                          + NUM_RX_MSGS * 25 + 40);

    logic        clk;
    logic        reset;
    clk_div_t    mbus_clk_div;
    short_addr_t short_addr_override;
    logic        mbus_clk;
    logic        host_frame_valid;
    eid_t        host_eid;
    char_t       host_char;
    logic        host_char_valid;
    logic        char_advance;
    mbus_word_t  tx_addr, tx_data;
    logic        tx_req, tx_pend, tx_ack, tx_fail, tx_succ, tx_resp_ack;
    mbus_word_t  rx_addr, rx_data;
    logic        rx_req, rx_pend, rx_fail, rx_broadcast, rx_ack;
    ctrl_bits_t  rx_ctrl_bits;
    logic        addr_write, addr_invalid, assigned_addr_valid;
    short_addr_t addr_write_value, assigned_addr;
    char_t       ack_data, rx_data_out, global_counter;
    logic        ack_data_valid, ack_frame_valid, rx_data_valid, rx_frame_valid;
    logic        global_counter_inc;

    int          mismatch_count = 0;
    int          other_count = 0;
    int          req_count = 0;
    int          inc_count = 0;
    logic        fail_next = 1'b0;
    mbus_word_t  exp_tx_addr;
    mbus_word_t  exp_data_q[$];
    logic        exp_pend_q[$];
    char_t       ack_exp[$];
    char_t       rx_exp[$];

    clock_gen #(.PERIOD_NS(CLK_PERIOD)) i_clock_gen (.clk(clk));

    mbus_layer_wrapper i_mbus_layer_wrapper (.*);

    bind mbus_layer_wrapper mbus_layer_checker i_mbus_layer_checker (
        .clk                (clk),
        .reset              (reset),
        .mbus_clk           (mbus_clk),
        .tx_req             (tx_req),
        .tx_ack_sync        (tx_ack_sync),
        .tx_pend            (tx_pend),
        .tx_resp_ack        (tx_resp_ack),
        .char_advance       (char_advance),
        .rx_ack             (rx_ack),
        .global_counter_inc (global_counter_inc),
        .ack_data_valid     (ack_data_valid),
        .ack_frame_valid    (ack_frame_valid),
        .rx_data_valid      (rx_data_valid),
        .rx_frame_valid     (rx_frame_valid)
    );

    // Expected RX message: type, time tag, flags, address, data
    function automatic logic [87:0] expected_rx_msg(input char_t stamp, input ctrl_bits_t ctrl,
            input logic broadcast, input logic pend, input logic fail,
            input mbus_word_t addr, input mbus_word_t data);
        char_t flags;
        flags = {3'b000, fail, pend, broadcast, ctrl};
        return {MSG_RX, stamp, flags, addr, data};
    endfunction

    // Expected ACK/NAK message: code, event id, zero
    function automatic logic [23:0] expected_ack_msg(input logic nak, input eid_t eid);
        return {nak ? MSG_NAK : MSG_ACK, eid, 8'h00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got == exp) else begin
            mismatch_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Offer one character until the driver takes it
    task automatic send_char(input char_t c);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            host_char       = c;
            host_char_valid = 1'b1;
            #1;
            taken = char_advance;
        end
    endtask

    task automatic check_mbus_clk_period(input int div);
        realtime t0;
        int      cycles;
        @(negedge clk);
        mbus_clk_div = clk_div_t'(div);
        // First edge after the change may close a shortened period
        @(posedge mbus_clk);
        @(posedge mbus_clk);
        t0 = $realtime;
        @(posedge mbus_clk);
        cycles = int'(($realtime - t0) / CLK_PERIOD);
        check_value("mbus_clk period", 32'(cycles), 32'(2 * (div + 1)));
    endtask

    task automatic run_tx_frame(input int num_words, input int extra_chars, input logic fail);
        mbus_word_t  word;
        logic [23:0] ack_msg;
        int          req_before;
        req_before  = req_count;
        fail_next   = fail;
        exp_tx_addr = $urandom;
        @(negedge clk);
        host_eid         = 8'($urandom);
        host_frame_valid = 1'b1;
        ack_msg = expected_ack_msg(fail || num_words == 0 || extra_chars != 0, host_eid);
        for (int i = 0; i < 3; i++) begin
            ack_exp.push_back(ack_msg[23 - 8 * i -: 8]);
        end
        for (int i = 0; i < 4; i++) begin
            send_char(exp_tx_addr[31 - 8 * i -: 8]);
        end
        for (int w = 0; w < num_words; w++) begin
            word = $urandom;
            exp_data_q.push_back(word);
            exp_pend_q.push_back(w != num_words - 1 || extra_chars != 0);
            for (int i = 0; i < 4; i++) begin
                send_char(word[31 - 8 * i -: 8]);
            end
        end
        for (int i = 0; i < extra_chars; i++) begin
            send_char(8'($urandom));
        end
        @(negedge clk);
        host_frame_valid = 1'b0;
        host_char_valid  = 1'b0;
        while (ack_exp.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        assert (exp_data_q.size() == 0) else begin
            other_count++;
            $display("Frame ended with data words that were never requested");
        end
        assert (num_words != 0 || req_count == req_before) else begin
            other_count++;
            $display("Frame without a complete data word raised a TX request");
        end
    endtask

    task automatic run_rx_messages(input int count);
        logic [87:0] msg;
        int          inc_before;
        inc_before = inc_count;
        for (int m = 0; m < count; m++) begin
            @(negedge clk);
            rx_addr      = $urandom;
            rx_data      = $urandom;
            rx_ctrl_bits = 2'($urandom);
            rx_broadcast = 1'($urandom);
            rx_pend      = 1'($urandom);
            rx_fail      = 1'($urandom);
            rx_req       = 1'b1;
            msg = expected_rx_msg(global_counter, rx_ctrl_bits, rx_broadcast, rx_pend,
                                  rx_fail, rx_addr, rx_data);
            for (int i = 0; i < 11; i++) begin
                rx_exp.push_back(msg[87 - 8 * i -: 8]);
            end
            while (!rx_ack) @(negedge clk);
            rx_req  = 1'b0;
            rx_pend = 1'b0;
            rx_fail = 1'b0;
            @(negedge clk);
            while (rx_frame_valid) @(negedge clk);
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end
        check_value("global_counter_inc count", 32'(inc_count - inc_before), 32'(count));
    endtask

    // One-cycle strobe, then room for the synchronizer and the register
    task automatic pulse_addr_strobe(input logic is_write);
        addr_write   = is_write;
        addr_invalid = !is_write;
        @(negedge clk);
        addr_write   = 1'b0;
        addr_invalid = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic check_short_addr(input short_addr_t exp_addr, input logic exp_valid);
        check_value("assigned_addr", 32'(assigned_addr), 32'(exp_addr));
        check_value("assigned_addr_valid", 32'(assigned_addr_valid), 32'(exp_valid));
    endtask

    // Controller TX side with its own random latencies
    initial begin : tx_controller
        logic last;
        tx_ack  = 1'b0;
        tx_succ = 1'b0;
        tx_fail = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_req && !tx_ack) begin
                req_count++;
                last = !tx_pend;
                assert (exp_data_q.size() != 0) else begin
                    other_count++;
                    $display("TX request raised with no data word left to send");
                end
                if (exp_data_q.size() != 0) begin
                    check_value("tx_addr", tx_addr, exp_tx_addr);
                    check_value("tx_data", tx_data, exp_data_q.pop_front());
                    check_value("tx_pend", 32'(tx_pend), 32'(exp_pend_q.pop_front()));
                end
                repeat ($urandom_range(0, 3)) @(negedge clk);
                tx_ack = 1'b1;
                while (tx_req) @(negedge clk);
                tx_ack = 1'b0;
                if (last) begin
                    repeat ($urandom_range(1, 4)) @(negedge clk);
                    tx_succ = !fail_next;
                    tx_fail = fail_next;
                    while (!tx_resp_ack) @(negedge clk);
                    tx_succ = 1'b0;
                    tx_fail = 1'b0;
                end
            end
        end
    end

    // Time tag counter advanced by the DUT
    initial begin : time_tag_counter
        global_counter = 8'h00;
        forever begin
            @(negedge clk);
            if (global_counter_inc) begin
                global_counter <= global_counter + 8'd1;
                inc_count++;
            end
        end
    end

    initial begin : compare_streams
        char_t expected;
        forever begin
            @(negedge clk);
            if (ack_data_valid) begin
                assert (ack_exp.size() != 0) else begin
                    other_count++;
                    $display("ACK stream sent a byte that no message expects");
                end
                if (ack_exp.size() != 0) begin
                    expected = ack_exp.pop_front();
                    check_value("ack_data", 32'(ack_data), 32'(expected));
                end
            end
            if (rx_data_valid) begin
                assert (rx_exp.size() != 0) else begin
                    other_count++;
                    $display("RX stream sent a byte that no message expects");
                end
                if (rx_exp.size() != 0) begin
                    expected = rx_exp.pop_front();
                    check_value("rx_data_out", 32'(rx_data_out), 32'(expected));
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d clock cycles, test sequence did not finish",
                 TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main_sequence
        void'($urandom(32'hae128923));
        reset               = 1'b1;
        mbus_clk_div        = clk_div_t'(1);
        short_addr_override = SHORT_ADDR_NONE;
        host_frame_valid    = 1'b0;
        host_eid            = 8'h00;
        host_char           = 8'h00;
        host_char_valid     = 1'b0;
        rx_addr             = '0;
        rx_data             = '0;
        rx_req              = 1'b0;
        rx_pend             = 1'b0;
        rx_fail             = 1'b0;
        rx_broadcast        = 1'b0;
        rx_ctrl_bits        = '0;
        addr_write          = 1'b0;
        addr_invalid        = 1'b0;
        addr_write_value    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        check_mbus_clk_period(1);
        check_mbus_clk_period(5);

        run_tx_frame(MAX_WORDS, 0, 1'b0);
        run_tx_frame(2, 0, 1'b1);
        // Address plus half a data word
        run_tx_frame(0, 2, 1'b0);
        run_tx_frame(1, 0, 1'b0);

        run_rx_messages(NUM_RX_MSGS);

        // Override wins whenever it is not the no-address value
        @(negedge clk);
        short_addr_override = 4'h5;
        @(negedge clk);
        check_short_addr(4'h5, 1'b1);
        short_addr_override = SHORT_ADDR_NONE;
        addr_write_value    = 4'h9;
        pulse_addr_strobe(1'b1);
        check_short_addr(4'h9, 1'b1);
        short_addr_override = 4'h3;
        @(negedge clk);
        check_short_addr(4'h3, 1'b1);
        short_addr_override = SHORT_ADDR_NONE;
        pulse_addr_strobe(1'b0);
        check_short_addr(SHORT_ADDR_NONE, 1'b0);

        assert (ack_exp.size() == 0 && rx_exp.size() == 0) else begin
            other_count++;
            $display("Expected output bytes never appeared");
        end

        $display("Error count: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
